/* hdl/boothPkg.sv */
`default_nettype none

package boothPkg;

	// Operand width of multiplicand and multiplier
	localparam int OperandWidth = 8;

	// One radix-4 digit per pair of multiplier bits
	localparam int NumDigits = OperandWidth / 2;

	// Signed multiplicand or multiplier
	typedef logic signed [OperandWidth-1:0] operandT;

	// Two guard bits so that twice the multiplicand never overflows
	typedef logic signed [OperandWidth+1:0] accT;

	// Full signed product
	typedef logic signed [2*OperandWidth-1:0] productT;

	// Remaining digits, must hold NumDigits
	typedef logic [2:0] stepCountT;

	// Controller states
	typedef enum logic [2:0] {
		Idle,
		Load,
		Add,
		Shift,
		Done
	} ctrlStateT;

endpackage

`default_nettype wire

/* hdl/boothController.sv */
`timescale 1ns/1ps
`default_nettype none

module boothController (
	input  wire  clk,
	input  wire  rst,
	input  wire  start,
	input  wire  lastStep,
	output logic loadOperands,
	output logic addStep,
	output logic shiftStep,
	output logic busy,
	output logic done
);

	import boothPkg::*;

	ctrlStateT state;
	ctrlStateT nextState;

	// Start only counts while no product is in flight
	logic acceptStart;

	// Last shift of the last digit
	logic finishStep;

	assign acceptStart = start && !busy;
	assign finishStep = (state == Shift) && lastStep;

	// State register
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= Idle;
		end
		else
		begin
			state <= nextState;
		end
	end

	// Next state
	always_comb
	begin
		nextState = state;
		case (state)
			Idle:
			begin
				if (acceptStart)
				begin
					nextState = Load;
				end
			end
			// One cycle to capture operands
			Load:
				nextState = Add;
			Add:
				nextState = Shift;
			// Loop back for the next digit or finish
			Shift:
			begin
				if (lastStep)
				begin
					nextState = Done;
				end
				else
				begin
					nextState = Add;
				end
			end
			// Back-to-back start skips the idle cycle
			Done:
			begin
				if (acceptStart)
				begin
					nextState = Load;
				end
				else
				begin
					nextState = Idle;
				end
			end
			default:
				nextState = Idle;
		endcase
	end

	// Busy set on the accepting edge, cleared as Done is entered
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
		end
		else if (acceptStart)
		begin
			busy <= 1'b1;
		end
		else if (finishStep)
		begin
			busy <= 1'b0;
		end
	end

	// Datapath strobes, one per state
	assign loadOperands = (state == Load);
	assign addStep = (state == Add);
	assign shiftStep = (state == Shift);

	// Single-cycle result pulse
	assign done = (state == Done);

endmodule

`default_nettype wire

/* hdl/stepCounter.sv */
`timescale 1ns/1ps
`default_nettype none

module stepCounter #(
	parameter int Steps = boothPkg::NumDigits
) (
	input  wire  clk,
	input  wire  rst,
	input  wire  load,
	input  wire  decrement,
	output logic lastStep
);

	import boothPkg::*;

	// Digits still to be processed
	stepCountT count;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			count <= '0;
		end
		else if (load)
		begin
			count <= stepCountT'(Steps);
		end
		// Hold at zero once exhausted
		else if (decrement && (count != '0))
		begin
			count <= count - 1'b1;
		end
	end

	// Final digit is in progress
	assign lastStep = (count == stepCountT'(1));

endmodule

`default_nettype wire

/* hdl/boothRecoder.sv */
`timescale 1ns/1ps
`default_nettype none

module boothRecoder (
	input  wire  boothPkg::operandT multiplicand,
	input  wire  [2:0]              recodeBits,
	output boothPkg::accT           partial
);

	import boothPkg::*;

	// Multiplicand widened with sign copies
	accT single;

	// Twice the multiplicand
	accT double;

	// Chosen magnitude before sign
	accT magnitude;

	// Digit is negative
	logic negate;

	assign single = {{2{multiplicand[OperandWidth-1]}}, multiplicand};
	assign double = {single[OperandWidth:0], 1'b0};

	// Radix-4 digit from bits {b1, b0, b-1}
	always_comb
	begin
		negate = recodeBits[2];
		case (recodeBits)
			// Run of zeros or ones, digit 0
			3'b000, 3'b111:
				magnitude = '0;
			// Digit +1
			3'b001, 3'b010:
				magnitude = single;
			// Digit +2
			3'b011:
				magnitude = double;
			// Digit -2
			3'b100:
				magnitude = double;
			// Digit -1
			default:
				magnitude = single;
		endcase
	end

	// Two's complement for negative digits
	assign partial = negate ? (~magnitude + accT'(1)) : magnitude;

endmodule

`default_nettype wire

/* hdl/boothDatapath.sv */
`timescale 1ns/1ps
`default_nettype none

module boothDatapath (
	input  wire  clk,
	input  wire  rst,
	input  wire  loadOperands,
	input  wire  addStep,
	input  wire  shiftStep,
	input  wire  boothPkg::operandT multiplicand,
	input  wire  boothPkg::operandT multiplier,
	output boothPkg::productT       product
);

	import boothPkg::*;

	// Captured multiplicand
	operandT mcandReg;

	// Multiplier, refilled from the top by accumulator bits
	operandT mplReg;

	// Running partial product, high half of the result
	accT acc;

	// Bit shifted out below the multiplier, b(-1) of the next digit
	logic carryBit;

	// Selected multiple of the multiplicand
	accT partial;

	// Three bits that pick the current digit
	logic [2:0] recodeBits;

	assign recodeBits = {mplReg[1:0], carryBit};

	boothRecoder recoder (
		.multiplicand(mcandReg),
		.recodeBits  (recodeBits),
		.partial     (partial)
	);

	// Multiplicand only changes on load
	always_ff @(posedge clk)
	begin
		if (loadOperands)
		begin
			mcandReg <= multiplicand;
		end
	end

	// Accumulator and multiplier shift as one long register
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			acc <= '0;
			mplReg <= '0;
			carryBit <= 1'b0;
		end
		else if (loadOperands)
		begin
			acc <= '0;
			mplReg <= multiplier;
			carryBit <= 1'b0;
		end
		else if (addStep)
		begin
			acc <= acc + partial;
		end
		else if (shiftStep)
		begin
			// Sign fills the top two accumulator bits
			acc <= acc >>> 2;
			// Low accumulator bits enter the multiplier from above
			mplReg <= {acc[1:0], mplReg[OperandWidth-1:2]};
			// Old bit 1 becomes the lookback bit
			carryBit <= mplReg[1];
		end
	end

	// Guard bits are only sign copies at the end
	assign product = {acc[OperandWidth-1:0], mplReg};

endmodule

`default_nettype wire

/* hdl/boothMultiplier.sv */
`timescale 1ns/1ps
`default_nettype none

module boothMultiplier (
	input  wire  clk,
	input  wire  rst,
	input  wire  start,
	input  wire  boothPkg::operandT multiplicand,
	input  wire  boothPkg::operandT multiplier,
	output logic busy,
	output logic done,
	output boothPkg::productT       product
);

	import boothPkg::*;

	// Controller strobes
	logic loadOperands;
	logic addStep;
	logic shiftStep;

	// Counter back to controller
	logic lastStep;

	// Sequencing of load, add and shift
	boothController controller (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.lastStep    (lastStep),
		.loadOperands(loadOperands),
		.addStep     (addStep),
		.shiftStep   (shiftStep),
		.busy        (busy),
		.done        (done)
	);

	// One count per Booth digit
	stepCounter #(
		.Steps(NumDigits)
	) counter (
		.clk      (clk),
		.rst      (rst),
		.load     (loadOperands),
		.decrement(shiftStep),
		.lastStep (lastStep)
	);

	// Operand registers, accumulator and recoder
	boothDatapath datapath (
		.clk         (clk),
		.rst         (rst),
		.loadOperands(loadOperands),
		.addStep     (addStep),
		.shiftStep   (shiftStep),
		.multiplicand(multiplicand),
		.multiplier  (multiplier),
		.product     (product)
	);

endmodule

`default_nettype wire

/* testbench/boothMultiplierTb.sv */
`timescale 1ns/1ps
`default_nettype none

module boothMultiplierTb;

	import boothPkg::*;

	// Test limits
	localparam int ResetCycles = 4;
	localparam int RandomTrials = 200;
	localparam int DoneTimeout = 40;
	localparam int unsigned Seed = 32'h228a_18e3;

	// Load cycle plus four add/shift pairs
	localparam int DoneLatency = 1 + 2 * NumDigits;

	// Edge index that never occurs, so no extra start is driven
	localparam int NoInterference = -1;

	// DUT inputs
	logic clk;
	logic rst;
	logic start;
	operandT multiplicand;
	operandT multiplier;

	// DUT outputs
	logic busy;
	logic done;
	productT product;

	// Result that must stay on product until the next accepted start
	productT heldProduct;

	boothMultiplier UUT (
		.clk         (clk),
		.rst         (rst),
		.start       (start),
		.multiplicand(multiplicand),
		.multiplier  (multiplier),
		.busy        (busy),
		.done        (done),
		.product     (product)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	// Print the reason, then stop the run
	task automatic reportFailure(input string message);
		$display("%s", message);
		$display("Finished with errors");
		$fatal(1);
	endtask

	// Compare one observed value with its expected value
	task automatic checkValue(
		input string       name,
		input logic [15:0] expected,
		input logic [15:0] actual
	);
		assert (actual === expected)
		else
		begin
			reportFailure($sformatf("Mismatch %s: expected 0x%0h, actual 0x%0h",
				name, expected, actual));
		end
	endtask

	// Outputs never unknown once out of reset
	assert property (@(posedge clk) disable iff (rst) !$isunknown({busy, done, product}))
	else
	begin
		reportFailure("busy, done or product is unknown after reset");
	end

	// Done is a single-cycle pulse
	assert property (@(posedge clk) disable iff (rst) done |=> !done)
	else
	begin
		reportFailure("done stayed high for more than one cycle");
	end

	// Busy has already fallen when done is high
	assert property (@(posedge clk) disable iff (rst) done |-> !busy)
	else
	begin
		reportFailure("busy and done were high in the same cycle");
	end

	// Busy only ends together with the done pulse
	assert property (@(posedge clk) disable iff (rst) busy |=> (busy || done))
	else
	begin
		reportFailure("busy fell without a done pulse");
	end

	// Result registers hold while nothing is in flight
	assert property (@(posedge clk) disable iff (rst) !busy |=> $stable(product))
	else
	begin
		reportFailure("product changed while the multiplier was not busy");
	end

	// Drive one start request and check that busy rises on the accepting edge
	task automatic launch(input operandT a, input operandT b);
		@(posedge clk);
		start <= 1'b1;
		multiplicand <= a;
		multiplier <= b;
		// Accepting edge, busy was low before it
		@(posedge clk);
		start <= 1'b0;
		@(negedge clk);
		assert (busy)
		else
		begin
			reportFailure("busy did not rise on the edge that accepted start");
		end
	endtask

	// Count edges after the accepting edge until done shows up
	task automatic waitForDone(
		input  int      interfereAt,
		input  operandT otherA,
		input  operandT otherB,
		output int      edges
	);
		edges = 0;
		while (!done && (edges < DoneTimeout))
		begin
			@(posedge clk);
			edges++;
			// Extra request in the middle of a run
			if (edges == interfereAt)
			begin
				start <= 1'b1;
				multiplicand <= otherA;
				multiplier <= otherB;
			end
			else if (edges == interfereAt + 1)
			begin
				start <= 1'b0;
			end
			@(negedge clk);
			// Busy covers every cycle before the result
			if (!done)
			begin
				assert (busy)
				else
				begin
					reportFailure($sformatf("busy dropped %0d edges after start before done",
						edges));
				end
			end
		end
		assert (done)
		else
		begin
			reportFailure($sformatf("done never came within %0d cycles after start",
				DoneTimeout));
		end
	endtask

	// One full multiplication with latency, handshake and product checks
	task automatic runAndCheck(
		input operandT a,
		input operandT b,
		input int      interfereAt,
		input operandT otherA,
		input operandT otherB
	);
		productT expected;
		int edges;

		// Signed product of the sign-extended operands
		expected = productT'(a) * productT'(b);

		launch(a, b);
		waitForDone(interfereAt, otherA, otherB, edges);

		checkValue("done latency", 16'(DoneLatency), 16'(edges));
		checkValue("busy", 16'h0, {15'h0, busy});
		checkValue("product", expected, product);
		heldProduct = expected;

		// Pulse is gone one cycle later, result still there
		@(negedge clk);
		checkValue("done", 16'h0, {15'h0, done});
		checkValue("product", heldProduct, product);
	endtask

	// Idle cycles, product must keep the last result
	task automatic idleAndCheckHold(input int cycles);
		repeat (cycles)
		begin
			@(negedge clk);
			checkValue("busy", 16'h0, {15'h0, busy});
			checkValue("done", 16'h0, {15'h0, done});
			checkValue("product", heldProduct, product);
		end
	endtask

	initial
	begin
		operandT a;
		operandT b;
		operandT otherA;
		operandT otherB;

		clk = 1'b0;
		rst = 1'b1;
		start = 1'b0;
		multiplicand = '0;
		multiplier = '0;
		heldProduct = '0;

		// Single seed for the whole run
		void'($urandom(Seed));

		repeat (ResetCycles)
		begin
			@(posedge clk);
		end
		rst <= 1'b0;

		// Reset values
		@(negedge clk);
		checkValue("busy", 16'h0, {15'h0, busy});
		checkValue("done", 16'h0, {15'h0, done});
		checkValue("product", 16'h0, product);
		idleAndCheckHold(2);

		// Corner operands
		runAndCheck(8'sh80, 8'sh80, NoInterference, '0, '0);
		idleAndCheckHold(1);
		runAndCheck(8'sh80, 8'sh7f, NoInterference, '0, '0);
		idleAndCheckHold(1);
		runAndCheck(8'sh7f, 8'sh80, NoInterference, '0, '0);
		idleAndCheckHold(1);
		runAndCheck(8'sh7f, 8'sh7f, NoInterference, '0, '0);
		idleAndCheckHold(1);
		runAndCheck(8'sh00, 8'sh80, NoInterference, '0, '0);
		idleAndCheckHold(1);
		runAndCheck(8'shff, 8'shff, NoInterference, '0, '0);
		idleAndCheckHold(1);
		runAndCheck(8'sh01, 8'shff, NoInterference, '0, '0);
		idleAndCheckHold(1);
		// Alternating bit patterns, digits -2 then -1
		runAndCheck(8'sh55, 8'shaa, NoInterference, '0, '0);
		idleAndCheckHold(1);

		// Start while busy, early in the run
		runAndCheck(8'sh5a, 8'shc3, 3, 8'sh7f, 8'sh7f);
		idleAndCheckHold(6);

		// Start while busy on the last edge before done
		runAndCheck(8'she7, 8'sh35, DoneLatency - 1, 8'sh80, 8'sh80);
		idleAndCheckHold(6);

		// Random operands, random gaps between runs
		for (int trial = 0; trial < RandomTrials; trial++)
		begin
			a = operandT'($urandom);
			b = operandT'($urandom);
			// Some runs also see a start that must be ignored
			if ($urandom_range(3, 0) == 0)
			begin
				otherA = operandT'($urandom);
				otherB = operandT'($urandom);
				runAndCheck(a, b, $urandom_range(DoneLatency - 1, 1), otherA, otherB);
			end
			else
			begin
				runAndCheck(a, b, NoInterference, '0, '0);
			end
			idleAndCheckHold($urandom_range(3, 0));
		end

		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* boothMultiplier.f */
hdl/boothPkg.sv
hdl/boothController.sv
hdl/stepCounter.sv
hdl/boothRecoder.sv
hdl/boothDatapath.sv
hdl/boothMultiplier.sv
testbench/boothMultiplierTb.sv
